// File: hdl/lstm_pkg.sv
package lstm_pkg;

        // Q3.20 fixed point in a 24-bit word
        localparam int WIDTH = 24;
        localparam int FRAC  = 20;

        typedef logic signed [WIDTH-1:0] data_t;

        // One weight or bias per gate
        typedef struct packed {
                data_t a;
                data_t i;
                data_t f;
                data_t o;
        } gate_vec_t;

        // Target memory of a weight load
        typedef enum logic [1:0] {
                BANK_W = 2'd0,
                BANK_U = 2'd1,
                BANK_B = 2'd2
        } bank_e;

        localparam data_t ONE  = data_t'(1 << FRAC);
        localparam data_t HALF = data_t'(1 << (FRAC - 1));

        // Index width, at least one bit
        function automatic int idx_w(int n);
                return (n > 1) ? $clog2(n) : 1;
        endfunction

        // Full product, then floor shift back to FRAC bits
        function automatic data_t fx_mul(data_t a, data_t b);
                logic signed [2*WIDTH-1:0] prod;
                prod = a * b;
                return data_t'(prod >>> FRAC);
        endfunction

        // x/4 + 0.5, limited to [0, 1]
        function automatic data_t hard_sigmoid(data_t x);
                data_t y;
                y = (x >>> 2) + HALF;
                if (y < 0) begin
                        return '0;
                end
                return (y > ONE) ? ONE : y;
        endfunction

        function automatic data_t hard_tanh(data_t x);
                if (x > ONE) begin
                        return ONE;
                end
                return (x < -ONE) ? -ONE : x;
        endfunction

endpackage

// File: hdl/lstm_ram.sv
module lstm_ram import lstm_pkg::*; #(
        parameter int  DEPTH     = 16,
        parameter type payload_t = data_t,
        localparam int AW        = idx_w(DEPTH)
) (
        input  logic          clk,
        input  logic          i_wr,
        input  logic [AW-1:0] i_wr_addr,
        input  payload_t      i_wr_data,
        input  logic [AW-1:0] i_rd_addr,
        output payload_t      o_rd_data
);

        payload_t mem [DEPTH];

        // Read data lags the address by one cycle
        always_ff @(posedge clk) begin
                if (i_wr) begin
                        mem[i_wr_addr] <= i_wr_data;
                end
                o_rd_data <= mem[i_rd_addr];
        end

        a_wr_range: assert property (@(posedge clk) i_wr |-> (i_wr_addr < DEPTH))
                else $error("lstm_ram write beyond depth %0d", DEPTH);

        a_rd_range: assert property (@(posedge clk) i_rd_addr < DEPTH)
                else $error("lstm_ram read beyond depth %0d", DEPTH);

endmodule

// File: hdl/lstm_index_counter.sv
module lstm_index_counter import lstm_pkg::*; #(
        parameter int  N_INPUT  = 4,
        parameter int  N_CELL   = 3,
        parameter int  TIMESTEP = 5,
        localparam int MAX_TERM = (N_INPUT > N_CELL) ? N_INPUT : N_CELL,
        localparam int STEP_W   = idx_w(TIMESTEP),
        localparam int CELL_W   = idx_w(N_CELL),
        localparam int TERM_W   = idx_w(MAX_TERM),
        localparam int X_AW     = idx_w(TIMESTEP * N_INPUT),
        localparam int W_AW     = idx_w(N_CELL * N_INPUT),
        localparam int U_AW     = idx_w(N_CELL * N_CELL),
        localparam int H_AW     = idx_w(2 * N_CELL)
) (
        input  logic              clk,
        input  logic              i_reset,
        input  logic              i_term_clr,
        input  logic              i_term_inc,
        input  logic              i_cell_inc,
        input  logic              i_cell_clr,
        input  logic              i_step_inc,
        input  logic              i_step_clr,
        input  logic              i_clear_mode,
        output logic              o_last_term_x,
        output logic              o_last_term_h,
        output logic              o_last_cell,
        output logic              o_last_step,
        output logic [X_AW-1:0]   o_x_addr,
        output logic [W_AW-1:0]   o_w_addr,
        output logic [U_AW-1:0]   o_u_addr,
        output logic [CELL_W-1:0] o_b_addr,
        output logic [H_AW-1:0]   o_h_rd_addr,
        output logic [H_AW-1:0]   o_h_wr_addr,
        output logic [CELL_W-1:0] o_c_addr,
        output logic [STEP_W-1:0] o_step,
        output logic [CELL_W-1:0] o_cell
);

        logic [STEP_W-1:0] step_q;
        logic [CELL_W-1:0] cell_q;
        logic [TERM_W-1:0] term_q;
        logic [TERM_W-1:0] term_x;
        logic [TERM_W-1:0] term_h;

        always_ff @(posedge clk) begin
                if (i_reset || i_term_clr) begin
                        term_q <= '0;
                end else if (i_term_inc) begin
                        term_q <= term_q + 1'b1;
                end
                if (i_reset || i_cell_clr) begin
                        cell_q <= '0;
                end else if (i_cell_inc) begin
                        cell_q <= o_last_cell ? '0 : cell_q + 1'b1;
                end
                if (i_reset || i_step_clr) begin
                        step_q <= '0;
                end else if (i_step_inc) begin
                        step_q <= step_q + 1'b1;
                end
        end

        assign o_last_term_x = term_q == TERM_W'(N_INPUT - 1);
        assign o_last_term_h = term_q == TERM_W'(N_CELL - 1);
        assign o_last_cell   = cell_q == CELL_W'(N_CELL - 1);
        assign o_last_step   = step_q == STEP_W'(TIMESTEP - 1);

        // The term index is shared, so keep each side inside its own matrix
        assign term_x = (term_q < N_INPUT) ? term_q : TERM_W'(N_INPUT - 1);
        assign term_h = (term_q < N_CELL) ? term_q : TERM_W'(N_CELL - 1);

        assign o_x_addr = X_AW'(step_q * N_INPUT + term_x);
        assign o_w_addr = W_AW'(cell_q * N_INPUT + term_x);
        assign o_u_addr = U_AW'(cell_q * N_CELL + term_h);
        assign o_b_addr = cell_q;
        assign o_c_addr = cell_q;

        // Even steps read bank 1 and write bank 0, odd steps the reverse
        assign o_h_rd_addr = H_AW'(step_q[0] ? term_h : N_CELL + term_h);
        assign o_h_wr_addr = H_AW'((i_clear_mode || step_q[0]) ? N_CELL + cell_q : cell_q);

        assign o_step = step_q;
        assign o_cell = cell_q;

        a_term_range: assert property (@(posedge clk) disable iff (i_reset)
                i_term_inc |-> (term_q < MAX_TERM - 1))
                else $error("term index stepped past %0d", MAX_TERM - 1);

endmodule

// File: hdl/lstm_sequencer.sv
module lstm_sequencer (
        input  logic clk,
        input  logic i_reset,
        input  logic i_start,
        input  logic i_last_term_x,
        input  logic i_last_term_h,
        input  logic i_last_cell,
        input  logic i_last_step,
        output logic o_term_clr,
        output logic o_term_inc,
        output logic o_cell_inc,
        output logic o_cell_clr,
        output logic o_step_inc,
        output logic o_step_clr,
        output logic o_clear_mode,
        output logic o_rd_en,
        output logic o_acc_x,
        output logic o_acc_h,
        output logic o_acc_clr,
        output logic o_compute,
        output logic o_h_wr,
        output logic o_c_wr,
        output logic o_clear_zero,
        output logic o_busy,
        output logic o_done,
        output logic o_h_valid
);

        typedef enum logic [3:0] {
                IDLE, CLEAR, ACC_CLR, MAC_X, MAC_H, DRAIN, COMPUTE, WRITE, DONE
        } state_e;

        state_e state_q;
        state_e state_d;

        always_ff @(posedge clk) begin
                if (i_reset) begin
                        state_q <= IDLE;
                end else begin
                        state_q <= state_d;
                end
        end

        always_comb begin
                state_d = state_q;
                case (state_q)
                        IDLE:    state_d = i_start ? CLEAR : IDLE;
                        CLEAR:   state_d = i_last_cell ? ACC_CLR : CLEAR;
                        ACC_CLR: state_d = MAC_X;
                        MAC_X:   state_d = i_last_term_x ? MAC_H : MAC_X;
                        MAC_H:   state_d = i_last_term_h ? DRAIN : MAC_H;
                        DRAIN:   state_d = COMPUTE;
                        COMPUTE: state_d = WRITE;
                        WRITE:   state_d = (i_last_cell && i_last_step) ? DONE : ACC_CLR;
                        default: state_d = IDLE;
                endcase
        end

        //////////////////////////////////////////////////
        // Phase strobes
        assign o_clear_mode = state_q == CLEAR;
        assign o_clear_zero = state_q == CLEAR;
        assign o_acc_clr    = state_q == ACC_CLR;
        assign o_acc_x      = state_q == MAC_X;
        assign o_acc_h      = state_q == MAC_H;
        assign o_rd_en      = o_acc_x || o_acc_h;
        assign o_compute    = state_q == COMPUTE;
        assign o_h_valid    = state_q == WRITE;
        assign o_done       = state_q == DONE;
        assign o_busy       = state_q != IDLE;

        // Clear phase zeroes c and h bank 1, one cell per cycle
        assign o_h_wr = o_h_valid || o_clear_mode;
        assign o_c_wr = o_h_valid || o_clear_mode;

        //////////////////////////////////////////////////
        // Counter steering
        assign o_cell_clr = state_q == IDLE;
        assign o_step_clr = state_q == IDLE;
        assign o_cell_inc = o_clear_mode || o_h_valid;
        assign o_step_inc = o_h_valid && i_last_cell && !i_last_step;
        assign o_term_inc = (o_acc_x && !i_last_term_x) || (o_acc_h && !i_last_term_h);
        assign o_term_clr = o_acc_clr || (o_acc_x && i_last_term_x)
                            || (o_acc_h && i_last_term_h);

        a_wr_vs_mac: assert property (@(posedge clk) disable iff (i_reset)
                !(o_h_wr && o_acc_x))
                else $error("hidden write during x accumulation");

endmodule

// File: hdl/gate_mac.sv
module gate_mac import lstm_pkg::*; (
        input  logic      clk,
        input  logic      i_reset,
        input  logic      i_clr,
        input  logic      i_acc_x,
        input  logic      i_acc_h,
        input  data_t     i_x,
        input  data_t     i_h,
        input  gate_vec_t i_w,
        input  gate_vec_t i_u,
        output gate_vec_t o_sum
);

        logic      acc_x_d;
        logic      acc_h_d;
        gate_vec_t coef;
        data_t     operand;
        gate_vec_t sum_q;

        // Strobes follow the address, data arrives a cycle later
        always_ff @(posedge clk) begin
                if (i_reset) begin
                        acc_x_d <= 1'b0;
                        acc_h_d <= 1'b0;
                end else begin
                        acc_x_d <= i_acc_x;
                        acc_h_d <= i_acc_h;
                end
        end

        // W pairs with x, U with the previous hidden value
        assign coef    = acc_x_d ? i_w : i_u;
        assign operand = acc_x_d ? i_x : i_h;

        always_ff @(posedge clk) begin
                if (i_reset || i_clr) begin
                        sum_q <= '0;
                end else if (acc_x_d || acc_h_d) begin
                        sum_q.a <= sum_q.a + fx_mul(coef.a, operand);
                        sum_q.i <= sum_q.i + fx_mul(coef.i, operand);
                        sum_q.f <= sum_q.f + fx_mul(coef.f, operand);
                        sum_q.o <= sum_q.o + fx_mul(coef.o, operand);
                end
        end

        assign o_sum = sum_q;

endmodule

// File: hdl/cell_update.sv
module cell_update import lstm_pkg::*; (
        input  logic      clk,
        input  logic      i_reset,
        input  logic      i_compute,
        input  logic      i_clear_zero,
        input  gate_vec_t i_sum,
        input  gate_vec_t i_bias,
        input  data_t     i_c_prev,
        output data_t     o_c,
        output data_t     o_h
);

        data_t pre_a;
        data_t pre_i;
        data_t pre_f;
        data_t pre_o;
        data_t act_a;
        data_t act_i;
        data_t act_f;
        data_t act_o;
        data_t c_next;
        data_t h_next;
        data_t c_q;
        data_t h_q;

        assign pre_a = i_sum.a + i_bias.a;
        assign pre_i = i_sum.i + i_bias.i;
        assign pre_f = i_sum.f + i_bias.f;
        assign pre_o = i_sum.o + i_bias.o;

        // Candidate uses tanh, the three gates use sigmoid
        assign act_a = hard_tanh(pre_a);
        assign act_i = hard_sigmoid(pre_i);
        assign act_f = hard_sigmoid(pre_f);
        assign act_o = hard_sigmoid(pre_o);

        assign c_next = fx_mul(act_f, i_c_prev) + fx_mul(act_i, act_a);
        assign h_next = fx_mul(act_o, hard_tanh(c_next));

        always_ff @(posedge clk) begin
                if (i_reset) begin
                        c_q <= '0;
                        h_q <= '0;
                end else if (i_compute) begin
                        c_q <= c_next;
                        h_q <= h_next;
                end
        end

        // Zero data for the clear phase writes
        assign o_c = i_clear_zero ? '0 : c_q;
        assign o_h = i_clear_zero ? '0 : h_q;

endmodule

// File: hdl/lstm_layer.sv
module lstm_layer import lstm_pkg::*; #(
        parameter int  N_INPUT  = 4,
        parameter int  N_CELL   = 3,
        parameter int  TIMESTEP = 5,
        localparam int X_DEPTH  = TIMESTEP * N_INPUT,
        localparam int W_DEPTH  = N_CELL * N_INPUT,
        localparam int U_DEPTH  = N_CELL * N_CELL,
        localparam int H_DEPTH  = 2 * N_CELL,
        localparam int X_AW     = idx_w(X_DEPTH),
        localparam int W_AW     = idx_w(W_DEPTH),
        localparam int U_AW     = idx_w(U_DEPTH),
        localparam int H_AW     = idx_w(H_DEPTH),
        localparam int CELL_W   = idx_w(N_CELL),
        localparam int STEP_W   = idx_w(TIMESTEP),
        localparam int LD_AW    = (W_AW > U_AW) ? W_AW : U_AW
) (
        input  logic              clk,
        input  logic              i_reset,
        input  logic              i_w_wr,
        input  bank_e             i_w_bank,
        input  logic [LD_AW-1:0]  i_w_addr,
        input  gate_vec_t         i_w_data,
        input  logic              i_x_wr,
        input  logic [X_AW-1:0]   i_x_addr,
        input  data_t             i_x_data,
        input  logic              i_start,
        output logic              o_busy,
        output logic              o_done,
        output logic              o_h_valid,
        output logic [STEP_W-1:0] o_h_step,
        output logic [CELL_W-1:0] o_h_cell,
        output data_t             o_h_data
);

        logic term_clr, term_inc, cell_inc, cell_clr, step_inc, step_clr, clear_mode;
        logic last_term_x, last_term_h, last_cell, last_step;
        logic rd_en, acc_x, acc_h, acc_clr, compute, h_wr, c_wr, clear_zero;
        logic [X_AW-1:0]   x_addr;
        logic [W_AW-1:0]   w_addr;
        logic [U_AW-1:0]   u_addr;
        logic [CELL_W-1:0] b_addr;
        logic [CELL_W-1:0] c_addr;
        logic [H_AW-1:0]   h_rd_addr;
        logic [H_AW-1:0]   h_wr_addr;
        gate_vec_t w_rd, u_rd, b_rd, sum;
        data_t     x_rd, h_rd, c_rd, c_new;

        //////////////////////////////////////////////////
        // Control
        lstm_sequencer u_seq (
                .clk           (clk),
                .i_reset       (i_reset),
                .i_start       (i_start),
                .i_last_term_x (last_term_x),
                .i_last_term_h (last_term_h),
                .i_last_cell   (last_cell),
                .i_last_step   (last_step),
                .o_term_clr    (term_clr),
                .o_term_inc    (term_inc),
                .o_cell_inc    (cell_inc),
                .o_cell_clr    (cell_clr),
                .o_step_inc    (step_inc),
                .o_step_clr    (step_clr),
                .o_clear_mode  (clear_mode),
                .o_rd_en       (rd_en),
                .o_acc_x       (acc_x),
                .o_acc_h       (acc_h),
                .o_acc_clr     (acc_clr),
                .o_compute     (compute),
                .o_h_wr        (h_wr),
                .o_c_wr        (c_wr),
                .o_clear_zero  (clear_zero),
                .o_busy        (o_busy),
                .o_done        (o_done),
                .o_h_valid     (o_h_valid)
        );

        lstm_index_counter #(.N_INPUT(N_INPUT), .N_CELL(N_CELL), .TIMESTEP(TIMESTEP)) u_idx (
                .clk           (clk),
                .i_reset       (i_reset),
                .i_term_clr    (term_clr),
                .i_term_inc    (term_inc),
                .i_cell_inc    (cell_inc),
                .i_cell_clr    (cell_clr),
                .i_step_inc    (step_inc),
                .i_step_clr    (step_clr),
                .i_clear_mode  (clear_mode),
                .o_last_term_x (last_term_x),
                .o_last_term_h (last_term_h),
                .o_last_cell   (last_cell),
                .o_last_step   (last_step),
                .o_x_addr      (x_addr),
                .o_w_addr      (w_addr),
                .o_u_addr      (u_addr),
                .o_b_addr      (b_addr),
                .o_h_rd_addr   (h_rd_addr),
                .o_h_wr_addr   (h_wr_addr),
                .o_c_addr      (c_addr),
                .o_step        (o_h_step),
                .o_cell        (o_h_cell)
        );

        //////////////////////////////////////////////////
        // Memories
        lstm_ram #(.DEPTH(W_DEPTH), .payload_t(gate_vec_t)) u_w_ram (
                .clk       (clk),
                .i_wr      (i_w_wr && (i_w_bank == BANK_W)),
                .i_wr_addr (i_w_addr[W_AW-1:0]),
                .i_wr_data (i_w_data),
                .i_rd_addr (w_addr),
                .o_rd_data (w_rd)
        );

        lstm_ram #(.DEPTH(U_DEPTH), .payload_t(gate_vec_t)) u_u_ram (
                .clk       (clk),
                .i_wr      (i_w_wr && (i_w_bank == BANK_U)),
                .i_wr_addr (i_w_addr[U_AW-1:0]),
                .i_wr_data (i_w_data),
                .i_rd_addr (u_addr),
                .o_rd_data (u_rd)
        );

        lstm_ram #(.DEPTH(N_CELL), .payload_t(gate_vec_t)) u_b_ram (
                .clk       (clk),
                .i_wr      (i_w_wr && (i_w_bank == BANK_B)),
                .i_wr_addr (i_w_addr[CELL_W-1:0]),
                .i_wr_data (i_w_data),
                .i_rd_addr (b_addr),
                .o_rd_data (b_rd)
        );

        lstm_ram #(.DEPTH(X_DEPTH), .payload_t(data_t)) u_x_ram (
                .clk       (clk),
                .i_wr      (i_x_wr),
                .i_wr_addr (i_x_addr),
                .i_wr_data (i_x_data),
                .i_rd_addr (x_addr),
                .o_rd_data (x_rd)
        );

        // Two hidden banks, one read while the other is written
        lstm_ram #(.DEPTH(H_DEPTH), .payload_t(data_t)) u_h_ram (
                .clk       (clk),
                .i_wr      (h_wr),
                .i_wr_addr (h_wr_addr),
                .i_wr_data (o_h_data),
                .i_rd_addr (h_rd_addr),
                .o_rd_data (h_rd)
        );

        lstm_ram #(.DEPTH(N_CELL), .payload_t(data_t)) u_c_ram (
                .clk       (clk),
                .i_wr      (c_wr),
                .i_wr_addr (c_addr),
                .i_wr_data (c_new),
                .i_rd_addr (c_addr),
                .o_rd_data (c_rd)
        );

        //////////////////////////////////////////////////
        // Datapath
        gate_mac u_mac (
                .clk     (clk),
                .i_reset (i_reset),
                .i_clr   (acc_clr),
                .i_acc_x (acc_x),
                .i_acc_h (acc_h),
                .i_x     (x_rd),
                .i_h     (h_rd),
                .i_w     (w_rd),
                .i_u     (u_rd),
                .o_sum   (sum)
        );

        cell_update u_cell (
                .clk          (clk),
                .i_reset      (i_reset),
                .i_compute    (compute),
                .i_clear_zero (clear_zero),
                .i_sum        (sum),
                .i_bias       (b_rd),
                .i_c_prev     (c_rd),
                .o_c          (c_new),
                .o_h          (o_h_data)
        );

        // Loads land only between runs, never under the MAC reads
        a_load_idle: assert property (@(posedge clk) disable iff (i_reset)
                rd_en |-> !(i_w_wr || i_x_wr))
                else $error("memory load during a run");

endmodule

// File: verification/tb_clock.sv
module tb_clock #(
        parameter int PERIOD = 10
) (
        output logic o_clk
);

        initial begin
                o_clk = 1'b0;
        end

        // Free running, half period high and half low
        always begin
                #(PERIOD / 2) o_clk = ~o_clk;
        end

endmodule

// File: verification/tb_lstm_model.svh
`ifndef TB_LSTM_MODEL_SVH
`define TB_LSTM_MODEL_SVH

// Activations that hit a limit in the last model run
int clamp_hits;

// Full product, floor shift by FRAC, low WIDTH bits kept
function automatic data_t mul_fixed(data_t a, data_t b);
        longint p;
        p = longint'(a) * longint'(b);
        return data_t'(p >>> FRAC);
endfunction

function automatic data_t sigmoid_ref(data_t x);
        int v;
        v = (int'(x) >>> 2) + (1 << (FRAC - 1));
        if (v < 0) begin
                clamp_hits++;
                v = 0;
        end else if (v > (1 << FRAC)) begin
                clamp_hits++;
                v = 1 << FRAC;
        end
        return data_t'(v);
endfunction

function automatic data_t tanh_ref(data_t x);
        int v;
        v = int'(x);
        if (v > (1 << FRAC)) begin
                clamp_hits++;
                v = 1 << FRAC;
        end else if (v < -(1 << FRAC)) begin
                clamp_hits++;
                v = -(1 << FRAC);
        end
        return data_t'(v);
endfunction

// One product per gate added into the running sums
function automatic gate_vec_t mac_gates(gate_vec_t acc, gate_vec_t coef, data_t operand);
        gate_vec_t r;
        r.a = acc.a + mul_fixed(coef.a, operand);
        r.i = acc.i + mul_fixed(coef.i, operand);
        r.f = acc.f + mul_fixed(coef.f, operand);
        r.o = acc.o + mul_fixed(coef.o, operand);
        return r;
endfunction

// Expected hidden sequence, zero initial h and c
task automatic compute_expected();
        data_t     h_prev [N_CELL];
        data_t     h_new [N_CELL];
        data_t     c_st [N_CELL];
        gate_vec_t acc;
        data_t     act_a;
        data_t     act_i;
        data_t     act_f;
        data_t     act_o;
        clamp_hits = 0;
        for (int k = 0; k < N_CELL; k++) begin
                h_prev[k] = '0;
                c_st[k] = '0;
        end
        for (int t = 0; t < TIMESTEP; t++) begin
                for (int k = 0; k < N_CELL; k++) begin
                        acc = b_arr[k];
                        for (int j = 0; j < N_INPUT; j++) begin
                                acc = mac_gates(acc, w_arr[k * N_INPUT + j],
                                                x_arr[t * N_INPUT + j]);
                        end
                        for (int m = 0; m < N_CELL; m++) begin
                                acc = mac_gates(acc, u_arr[k * N_CELL + m], h_prev[m]);
                        end
                        act_a = tanh_ref(acc.a);
                        act_i = sigmoid_ref(acc.i);
                        act_f = sigmoid_ref(acc.f);
                        act_o = sigmoid_ref(acc.o);
                        c_st[k] = mul_fixed(act_f, c_st[k]) + mul_fixed(act_i, act_a);
                        h_new[k] = mul_fixed(act_o, tanh_ref(c_st[k]));
                        exp_h[t * N_CELL + k] = h_new[k];
                end
                h_prev = h_new;
        end
endtask

`endif

// File: verification/tb_lstm_layer.sv
module tb_lstm_layer import lstm_pkg::*; ();

        localparam int N_INPUT     = 4;
        localparam int N_CELL      = 3;
        localparam int TIMESTEP    = 5;
        localparam int X_AW        = idx_w(TIMESTEP * N_INPUT);
        localparam int W_AW        = idx_w(N_CELL * N_INPUT);
        localparam int U_AW        = idx_w(N_CELL * N_CELL);
        localparam int LD_AW       = (W_AW > U_AW) ? W_AW : U_AW;
        localparam int CELL_W      = idx_w(N_CELL);
        localparam int STEP_W      = idx_w(TIMESTEP);
        localparam int RUN_TIMEOUT = 2000;
        localparam int SMALL       = 2 << FRAC;
        localparam int LARGE       = 7 << FRAC;

        logic              clk;
        logic              i_reset;
        logic              i_w_wr;
        bank_e             i_w_bank;
        logic [LD_AW-1:0]  i_w_addr;
        gate_vec_t         i_w_data;
        logic              i_x_wr;
        logic [X_AW-1:0]   i_x_addr;
        data_t             i_x_data;
        logic              i_start;
        logic              o_busy;
        logic              o_done;
        logic              o_h_valid;
        logic [STEP_W-1:0] o_h_step;
        logic [CELL_W-1:0] o_h_cell;
        data_t             o_h_data;

        // Loaded contents, kept for the model
        gate_vec_t w_arr [N_CELL * N_INPUT];
        gate_vec_t u_arr [N_CELL * N_CELL];
        gate_vec_t b_arr [N_CELL];
        data_t     x_arr [TIMESTEP * N_INPUT];
        data_t     exp_h [TIMESTEP * N_CELL];
        integer    seed = 32'h2a42;

        `include "tb_lstm_model.svh"

        tb_clock #(.PERIOD(10)) u_clock (.o_clk(clk));

        lstm_layer #(.N_INPUT(N_INPUT), .N_CELL(N_CELL), .TIMESTEP(TIMESTEP)) DUT (
                .clk       (clk),
                .i_reset   (i_reset),
                .i_w_wr    (i_w_wr),
                .i_w_bank  (i_w_bank),
                .i_w_addr  (i_w_addr),
                .i_w_data  (i_w_data),
                .i_x_wr    (i_x_wr),
                .i_x_addr  (i_x_addr),
                .i_x_data  (i_x_data),
                .i_start   (i_start),
                .o_busy    (o_busy),
                .o_done    (o_done),
                .o_h_valid (o_h_valid),
                .o_h_step  (o_h_step),
                .o_h_cell  (o_h_cell),
                .o_h_data  (o_h_data)
        );

        //////////////////////////////////////////////////
        // Failure handling and checks
        task automatic abort_test(input string reason);
                $display("%s", reason);
                $display("Test failures found");
                $fatal(1, "Simulation stopped at the first failure");
        endtask

        task automatic check_value(input int actual, input int expected, input string what);
                if (actual != expected) begin
                        abort_test($sformatf("[ERROR] %0t: %s is %0d, expected %0d",
                                             $time, what, actual, expected));
                end
        endtask

        //////////////////////////////////////////////////
        // Stimulus
        function automatic data_t rand_fixed(input int range);
                return data_t'($random(seed) % range);
        endfunction

        function automatic gate_vec_t rand_gates(input int range);
                gate_vec_t g;
                g.a = rand_fixed(range);
                g.i = rand_fixed(range);
                g.f = rand_fixed(range);
                g.o = rand_fixed(range);
                return g;
        endfunction

        task automatic randomize_arrays(input int w_range);
                foreach (w_arr[n]) w_arr[n] = rand_gates(w_range);
                foreach (u_arr[n]) u_arr[n] = rand_gates(w_range);
                foreach (b_arr[n]) b_arr[n] = rand_gates(w_range);
                foreach (x_arr[n]) x_arr[n] = rand_fixed(SMALL);
        endtask

        task automatic write_gates(input bank_e bank, input int addr, input gate_vec_t data);
                @(posedge clk);
                i_w_wr   <= 1'b1;
                i_w_bank <= bank;
                i_w_addr <= LD_AW'(addr);
                i_w_data <= data;
        endtask

        task automatic load_memories();
                foreach (w_arr[n]) write_gates(BANK_W, n, w_arr[n]);
                foreach (u_arr[n]) write_gates(BANK_U, n, u_arr[n]);
                foreach (b_arr[n]) write_gates(BANK_B, n, b_arr[n]);
                @(posedge clk);
                i_w_wr <= 1'b0;
                foreach (x_arr[n]) begin
                        i_x_wr   <= 1'b1;
                        i_x_addr <= X_AW'(n);
                        i_x_data <= x_arr[n];
                        @(posedge clk);
                end
                i_x_wr <= 1'b0;
        endtask

        // Outputs are sampled on the falling edge
        task automatic check_idle(input int n_cycles);
                repeat (n_cycles) begin
                        @(negedge clk);
                        check_value(o_busy, 0, "o_busy while idle");
                        check_value(o_done, 0, "o_done while idle");
                        check_value(o_h_valid, 0, "o_h_valid while idle");
                end
        endtask

        // Start a run, check every result, optionally pulse start again mid run
        task automatic run_layer(input int extra_start_at);
                int cycles;
                int n_out;
                bit finished;
                cycles = 0;
                n_out = 0;
                finished = 1'b0;
                @(posedge clk);
                i_start <= 1'b1;
                @(negedge clk);
                while (!finished) begin
                        @(posedge clk);
                        i_start <= (cycles == extra_start_at);
                        @(negedge clk);
                        cycles++;
                        if (cycles > RUN_TIMEOUT) begin
                                abort_test("Timed out waiting for o_done from the DUT");
                        end
                        check_value(o_busy, 1, "o_busy during run");
                        if (o_h_valid) begin
                                if (n_out >= TIMESTEP * N_CELL) begin
                                        abort_test("DUT produced more results than expected");
                                end
                                check_value(o_h_step, n_out / N_CELL, "o_h_step");
                                check_value(o_h_cell, n_out % N_CELL, "o_h_cell");
                                check_value(o_h_data, exp_h[n_out], "o_h_data");
                                n_out++;
                        end
                        finished = o_done;
                end
                check_value(n_out, TIMESTEP * N_CELL, "result count");
                cycles = 0;
                do begin
                        @(negedge clk);
                        cycles++;
                        if (cycles > 4) begin
                                abort_test("o_busy stayed high after o_done");
                        end
                        check_value(o_done, 0, "o_done after the run");
                end while (o_busy);
        endtask

        //////////////////////////////////////////////////
        // Test sequence
        initial begin
                i_reset  = 1'b1;
                i_w_wr   = 1'b0;
                i_w_bank = BANK_W;
                i_w_addr = '0;
                i_w_data = '0;
                i_x_wr   = 1'b0;
                i_x_addr = '0;
                i_x_data = '0;
                i_start  = 1'b0;
                repeat (3) @(posedge clk);
                i_reset <= 1'b0;

                check_idle(10);

                randomize_arrays(SMALL);
                load_memories();
                compute_expected();
                run_layer(-1);

                // New data, state must start from zero again
                randomize_arrays(SMALL);
                load_memories();
                compute_expected();
                run_layer(-1);

                // Large weights drive the gates into the clamps
                randomize_arrays(LARGE);
                load_memories();
                compute_expected();
                if (clamp_hits == 0) begin
                        abort_test("Saturation run never drove an activation into clamping");
                end
                run_layer(-1);

                // Start pulse in the middle of a run
                randomize_arrays(SMALL);
                load_memories();
                compute_expected();
                run_layer(20);
                check_idle(20);

                $display("All tests passed!");
                $finish;
        end

endmodule

// File: filelist.f
+incdir+verification
hdl/lstm_pkg.sv
hdl/lstm_ram.sv
hdl/lstm_index_counter.sv
hdl/lstm_sequencer.sv
hdl/gate_mac.sv
hdl/cell_update.sv
hdl/lstm_layer.sv
verification/tb_clock.sv
verification/tb_lstm_layer.sv

// File: run.sh
#!/bin/sh
# Build the LSTM layer testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal --top-module tb_lstm_layer \
        -f filelist.f -o sim_lstm_layer &&
./obj_dir/sim_lstm_layer | tee /dev/stderr | grep -q "All tests passed!" &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }
